/* rtl/synth_regs_pkg.sv */
// host register map, control bit positions and bus-side timing constants for the sound core
package synth_regs_pkg;

    // internal clock enable and busy window
    localparam int clk_div        = 6;   // clk cycles per clk_en tick
    localparam int busy_ticks     = 32;  // clk_en ticks of busy after a data write
    localparam int tmr_b_prescale = 16;  // clk_en ticks per timer B count

    // timer registers
    localparam logic [7:0] reg_tmr_a_hi = 8'h24;  // value A bits 9..2
    localparam logic [7:0] reg_tmr_a_lo = 8'h25;  // value A bits 1..0
    localparam logic [7:0] reg_tmr_b    = 8'h26;
    localparam logic [7:0] reg_tmr_ctl  = 8'h27;

    // key on/off
    localparam logic [7:0] reg_key = 8'h28;

    // per-channel registers, channel index added to the base
    localparam logic [7:0] reg_level_base   = 8'h40;
    localparam logic [7:0] reg_fnum_lo_base = 8'ha0;
    localparam logic [7:0] reg_fnum_hi_base = 8'ha4;
    localparam logic [7:0] reg_pan_base     = 8'hb4;

    // timer control bits
    localparam int ctl_load_a  = 0;
    localparam int ctl_load_b  = 1;
    localparam int ctl_irq_a   = 2;
    localparam int ctl_irq_b   = 3;
    localparam int ctl_clr_a   = 4;  // strobe, not stored
    localparam int ctl_clr_b   = 5;  // strobe, not stored

    // key register bits
    localparam int key_on_bit  = 4;

    // pan register bits
    localparam int pan_l_bit   = 7;
    localparam int pan_r_bit   = 6;

endpackage

/* rtl/synth_voice_pkg.sv */
// channel count and datapath widths and types shared by the voice path and its testbench
package synth_voice_pkg;

    localparam int num_ch   = 3;

    localparam int ch_w     = 2;
    localparam int fnum_w   = 11;
    localparam int block_w  = 3;
    localparam int phase_w  = 20;
    localparam int level_w  = 7;
    localparam int sample_w = 12;

    // channel index within a frame
    typedef logic [ch_w-1:0] ch_t;

    // frequency number and octave
    typedef logic [fnum_w-1:0] fnum_t;
    typedef logic [block_w-1:0] block_t;

    // phase accumulator, top bit gives the square tone
    typedef logic [phase_w-1:0] phase_t;

    // output level, unsigned
    typedef logic [level_w-1:0] level_t;

    // mixed output sample
    typedef logic signed [sample_w-1:0] sample_t;

endpackage

/* rtl/synth_timer.sv */
// loadable up-counting interval timer with overflow flag, instantiated for timers A and B
`timescale 1ns/1ns

module synth_timer #(
    parameter type count_t  = logic [9:0],
    parameter int  prescale = 1            // clk_en ticks per count
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   clk_en,
    input  count_t value,
    input  logic   load,
    input  logic   clr,
    output logic   flag
);

    localparam int pre_w = (prescale > 1) ? $clog2(prescale) : 1;

    count_t           count;
    logic [pre_w-1:0] pre_cnt;
    logic             tick;
    logic             overflow;

    assign tick     = clk_en && pre_cnt == pre_w'(prescale - 1);
    assign overflow = load && tick && count == '1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            pre_cnt <= '0;
            flag    <= 1'b0;
        end else begin
            if (!load) begin
                count   <= value;   // parked at start value
                pre_cnt <= '0;
            end else if (clk_en) begin
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                if (overflow)
                    count <= value;
                else if (tick)
                    count <= count + 1'b1;
            end

            // set wins over clear
            if (clr)
                flag <= 1'b0;
            if (overflow)
                flag <= 1'b1;
        end
    end

endmodule

/* rtl/synth_pg.sv */
// phase generator: slot sequencer and per-channel phase accumulators with key-on reset
`timescale 1ns/1ns

module synth_pg
    import synth_voice_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clk_en,
    input  fnum_t  [num_ch-1:0]    fnum,
    input  block_t [num_ch-1:0]    block,
    input  logic   [num_ch-1:0]    key_on,
    output ch_t                    slot,
    output logic                   slot_valid,
    output logic                   phase_msb,
    output logic                   key
);

    phase_t            phase [num_ch];
    ch_t               slot_cnt;     // slot served on the next clk_en
    logic [num_ch-1:0] key_lat;      // keys of the current frame
    logic [num_ch-1:0] rise_pend;    // key rose this frame
    logic [num_ch-1:0] key_now;
    logic [num_ch-1:0] rise_now;
    phase_t            inc;
    phase_t            next_phase;

    // slot 0 sees the keys directly, later slots use the latched copy
    always_comb begin
        key_now    = (slot_cnt == '0) ? key_on : key_lat;
        rise_now   = (slot_cnt == '0) ? (key_on & ~key_lat) : rise_pend;
        inc        = phase_t'(fnum[slot_cnt]) << block[slot_cnt];
        next_phase = rise_now[slot_cnt] ? '0 : phase[slot_cnt] + inc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_cnt   <= '0;
            key_lat    <= '0;
            rise_pend  <= '0;
            slot       <= '0;
            slot_valid <= 1'b0;
            phase_msb  <= 1'b0;
            key        <= 1'b0;
            for (int i = 0; i < num_ch; i++)
                phase[i] <= '0;
        end else begin
            slot_valid <= clk_en;
            if (clk_en) begin
                phase[slot_cnt] <= next_phase;
                slot            <= slot_cnt;
                phase_msb       <= next_phase[phase_w-1];
                key             <= key_now[slot_cnt];

                if (slot_cnt == '0) begin
                    key_lat   <= key_on;
                    rise_pend <= key_on & ~key_lat;
                end

                if (slot_cnt == ch_t'(num_ch - 1))
                    slot_cnt <= '0;   // frame wraps
                else
                    slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/synth_acc.sv */
// stereo accumulator: sums square-wave channel contributions per frame and strobes the sample
`timescale 1ns/1ns

module synth_acc
    import synth_voice_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  ch_t                      slot,
    input  logic                     slot_valid,
    input  logic                     phase_msb,
    input  logic                     key,
    input  level_t [num_ch-1:0]      level,
    input  logic   [num_ch-1:0][1:0] pan,      // [1] left, [0] right
    output sample_t                  left,
    output sample_t                  right,
    output logic                     sample
);

    sample_t contrib;
    sample_t left_sum;
    sample_t right_sum;
    sample_t left_next;
    sample_t right_next;
    logic    last_slot;

    assign last_slot = slot_valid && slot == ch_t'(num_ch - 1);

    always_comb begin
        // square wave, +level on the low half and -level on the high half
        contrib    = phase_msb ? -sample_t'(level[slot]) : sample_t'(level[slot]);
        left_next  = left_sum;
        right_next = right_sum;
        if (slot_valid && key) begin
            if (pan[slot][1])
                left_next = left_sum + contrib;
            if (pan[slot][0])
                right_next = right_sum + contrib;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            left_sum  <= '0;
            right_sum <= '0;
            left      <= '0;
            right     <= '0;
            sample    <= 1'b0;
        end else begin
            sample <= last_slot;
            if (last_slot) begin
                left      <= left_next;   // held until next frame
                right     <= right_next;
                left_sum  <= '0;
                right_sum <= '0;
            end else if (slot_valid) begin
                left_sum  <= left_next;
                right_sum <= right_next;
            end
        end
    end

endmodule

/* rtl/synth_mmr.sv */
// host register file: address latch, register decode, clk_en prescaler, busy and status/irq
`timescale 1ns/1ns

module synth_mmr
    import synth_regs_pkg::*;
    import synth_voice_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [7:0]               din,
    input  logic                     a0,
    input  logic                     cs_n,
    input  logic                     wr_n,
    input  logic                     flag_a,
    input  logic                     flag_b,
    output logic [7:0]               dout,
    output logic                     irq_n,
    output logic                     clk_en,
    output logic [9:0]               value_a,
    output logic [7:0]               value_b,
    output logic                     load_a,
    output logic                     load_b,
    output logic                     clr_a,
    output logic                     clr_b,
    output fnum_t  [num_ch-1:0]      fnum,
    output block_t [num_ch-1:0]      block,
    output logic   [num_ch-1:0]      key_on,
    output level_t [num_ch-1:0]      level,
    output logic   [num_ch-1:0][1:0] pan     // [1] left, [0] right
);

    localparam int div_w  = $clog2(clk_div);
    localparam int busy_w = $clog2(busy_ticks + 1);

    logic              write;
    logic              data_wr;
    logic              busy;
    logic [7:0]        addr;
    logic [div_w-1:0]  div_cnt;
    logic [busy_w-1:0] busy_cnt;
    logic              irq_en_a;
    logic              irq_en_b;
    ch_t               key_ch;

    assign write   = !cs_n && !wr_n;
    assign data_wr = write && a0 && !busy;   // dropped while busy
    assign busy    = busy_cnt != '0;
    assign key_ch  = din[1:0];

    assign dout  = {busy, 5'd0, flag_b, flag_a};
    assign irq_n = !((flag_a && irq_en_a) || (flag_b && irq_en_b));

    // control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr     <= '0;
            div_cnt  <= '0;
            clk_en   <= 1'b0;
            busy_cnt <= '0;
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            clr_a    <= 1'b0;
            clr_b    <= 1'b0;
            key_on   <= '0;
        end else begin
            // one tick every clk_div clocks
            if (div_cnt == div_w'(clk_div - 1)) begin
                div_cnt <= '0;
                clk_en  <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                clk_en  <= 1'b0;
            end

            if (write && !a0)
                addr <= din;   // address phase

            if (data_wr)
                busy_cnt <= busy_w'(busy_ticks);
            else if (clk_en && busy)
                busy_cnt <= busy_cnt - 1'b1;

            clr_a <= data_wr && addr == reg_tmr_ctl && din[ctl_clr_a];
            clr_b <= data_wr && addr == reg_tmr_ctl && din[ctl_clr_b];

            if (data_wr && addr == reg_tmr_ctl) begin
                load_a   <= din[ctl_load_a];
                load_b   <= din[ctl_load_b];
                irq_en_a <= din[ctl_irq_a];
                irq_en_b <= din[ctl_irq_b];
            end

            if (data_wr && addr == reg_key && key_ch < num_ch)
                key_on[key_ch] <= din[key_on_bit];
        end
    end

    // timer values and channel settings
    always_ff @(posedge clk) begin
        if (data_wr) begin
            case (addr)
                reg_tmr_a_hi: value_a[9:2] <= din;
                reg_tmr_a_lo: value_a[1:0] <= din[1:0];
                reg_tmr_b:    value_b      <= din;
                default: ;
            endcase
            for (int ch = 0; ch < num_ch; ch++) begin
                if (addr == reg_fnum_lo_base + 8'(ch))
                    fnum[ch][7:0] <= din;
                if (addr == reg_fnum_hi_base + 8'(ch)) begin
                    block[ch]      <= din[5:3];
                    fnum[ch][10:8] <= din[2:0];
                end
                if (addr == reg_pan_base + 8'(ch))
                    pan[ch] <= {din[pan_l_bit], din[pan_r_bit]};
                if (addr == reg_level_base + 8'(ch))
                    level[ch] <= din[6:0];
            end
        end
    end

endmodule

/* rtl/synth_top.sv */
// sound core top level: register file, timers A and B, phase generator and stereo mixer
`timescale 1ns/1ns

module synth_top
    import synth_regs_pkg::*;
    import synth_voice_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] din,
    input  logic       a0,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n,
    output sample_t    left,
    output sample_t    right,
    output logic       sample
);

    logic                     clk_en;
    logic                     flag_a;
    logic                     flag_b;
    logic [9:0]               value_a;
    logic [7:0]               value_b;
    logic                     load_a;
    logic                     load_b;
    logic                     clr_a;
    logic                     clr_b;
    fnum_t  [num_ch-1:0]      fnum;
    block_t [num_ch-1:0]      block;
    logic   [num_ch-1:0]      key_on;
    level_t [num_ch-1:0]      level;
    logic   [num_ch-1:0][1:0] pan;
    ch_t                      slot;
    logic                     slot_valid;
    logic                     phase_msb;
    logic                     key;

    synth_mmr u_mmr (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .din     ( din     ),
        .a0      ( a0      ),
        .cs_n    ( cs_n    ),
        .wr_n    ( wr_n    ),
        .flag_a  ( flag_a  ),
        .flag_b  ( flag_b  ),
        .dout    ( dout    ),
        .irq_n   ( irq_n   ),
        .clk_en  ( clk_en  ),
        .value_a ( value_a ),
        .value_b ( value_b ),
        .load_a  ( load_a  ),
        .load_b  ( load_b  ),
        .clr_a   ( clr_a   ),
        .clr_b   ( clr_b   ),
        .fnum    ( fnum    ),
        .block   ( block   ),
        .key_on  ( key_on  ),
        .level   ( level   ),
        .pan     ( pan     )
    );

    // timer A counts every tick
    synth_timer #(.count_t(logic [9:0]), .prescale(1)) u_timer_a (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .clk_en ( clk_en  ),
        .value  ( value_a ),
        .load   ( load_a  ),
        .clr    ( clr_a   ),
        .flag   ( flag_a  )
    );

    synth_timer #(.count_t(logic [7:0]), .prescale(tmr_b_prescale)) u_timer_b (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .clk_en ( clk_en  ),
        .value  ( value_b ),
        .load   ( load_b  ),
        .clr    ( clr_b   ),
        .flag   ( flag_b  )
    );

    synth_pg u_pg (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .clk_en     ( clk_en     ),
        .fnum       ( fnum       ),
        .block      ( block      ),
        .key_on     ( key_on     ),
        .slot       ( slot       ),
        .slot_valid ( slot_valid ),
        .phase_msb  ( phase_msb  ),
        .key        ( key        )
    );

    synth_acc u_acc (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .slot       ( slot       ),
        .slot_valid ( slot_valid ),
        .phase_msb  ( phase_msb  ),
        .key        ( key        ),
        .level      ( level      ),
        .pan        ( pan        ),
        .left       ( left       ),
        .right      ( right      ),
        .sample     ( sample     )
    );

endmodule

/* test/synth_tb.sv */
// directed testbench for the sound core top level: bus, busy window, timers and voice mixing
`timescale 1ns/1ns

module synth_tb
    import synth_regs_pkg::*;
    import synth_voice_pkg::*;
();

    localparam int frame_len   = num_ch * clk_div;
    localparam int write_len   = busy_ticks * clk_div + 2 * frame_len;
    localparam int test_len    = 40 * write_len + 104 * clk_div
                               + 6 * tmr_b_prescale * clk_div + 70 * frame_len;
    localparam int cycle_limit = test_len + test_len / 2;

    logic       clk = 1'b0;
    logic       arst_n;
    logic [7:0] din;
    logic       a0;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;
    sample_t    left;
    sample_t    right;
    logic       sample;

    integer seed         = 32'h9782_65e5;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     frames_seen  = 0;
    int     cycles       = 0;
    int     first_strobe = -1;
    string  cur_test     = "reset";

    // reference voice state, one entry per channel
    fnum_t             m_fnum  [num_ch];
    block_t            m_block [num_ch];
    level_t            m_level [num_ch];
    logic [1:0]        m_pan   [num_ch];   // [1] left, [0] right
    phase_t            m_phase [num_ch];
    logic [num_ch-1:0] m_key   = '0;
    logic [num_ch-1:0] m_fresh = '0;       // keyed on, no update yet

    synth_top i_dut (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .din    ( din    ),
        .a0     ( a0     ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  ),
        .left   ( left   ),
        .right  ( right  ),
        .sample ( sample )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d clock cycles, run stopped", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_status(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: status expected 8'h%02h, got 8'h%02h", name, exp, act);
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: irq_n expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: sample expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: sample strobe expected %b, got %b", name, exp, act);
        end
    endtask

    // k-th strobe after key on shows k-1 phase updates
    task automatic step_model();
        for (int ch = 0; ch < num_ch; ch++) begin
            if (m_key[ch]) begin
                if (m_fresh[ch])
                    m_fresh[ch] = 1'b0;
                else
                    m_phase[ch] = m_phase[ch] + (phase_t'(m_fnum[ch]) << m_block[ch]);
            end
        end
    endtask

    function automatic sample_t model_sum(input logic want_left);
        sample_t sum;
        sample_t c;
        sum = '0;
        for (int ch = 0; ch < num_ch; ch++) begin
            if (m_key[ch] && (want_left ? m_pan[ch][1] : m_pan[ch][0])) begin
                c = sample_t'(m_level[ch]);
                sum = m_phase[ch][phase_w-1] ? sum - c : sum + c;   // square tone
            end
        end
        return sum;
    endfunction

    // every strobe is checked against the model, whatever the test is doing
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (first_strobe < 0 && sample)
            first_strobe = cycles;   // fixes the frame grid
        if (first_strobe >= 0)
            check_strobe(cur_test, (cycles - first_strobe) % frame_len == 0, sample);
        if (sample) begin
            frames_seen++;
            step_model();
            check_sample({cur_test, " left"}, model_sum(1'b1), left);
            check_sample({cur_test, " right"}, model_sum(1'b0), right);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target)
            next_cycle();
    endtask

    task automatic bus_write(input logic sel, input logic [7:0] data);
        a0   = sel;
        din  = data;
        cs_n = 1'b0;
        wr_n = 1'b0;
        next_cycle();
        cs_n = 1'b1;
        wr_n = 1'b1;
        a0   = 1'b0;
    endtask

    task automatic wait_not_busy();
        while (dout[7])
            next_cycle();
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        bus_write(1'b0, addr);
        wait_not_busy();
        bus_write(1'b1, data);
    endtask

    task automatic set_channel(input ch_t ch, input fnum_t f, input block_t b,
                               input level_t lv, input logic [1:0] p);
        write_reg(reg_fnum_lo_base + 8'(ch), f[7:0]);
        write_reg(reg_fnum_hi_base + 8'(ch), {2'b00, b, f[10:8]});
        write_reg(reg_pan_base + 8'(ch), {p, 6'd0});
        write_reg(reg_level_base + 8'(ch), {1'b0, lv});
        m_fnum[ch]  = f;
        m_block[ch] = b;
        m_level[ch] = lv;
        m_pan[ch]   = p;
    endtask

    // data phase goes out right after a strobe, before the next slot 0
    task automatic key_write(input ch_t ch, input logic on);
        logic [7:0] data;
        data = 8'(ch);
        data[key_on_bit] = on;
        bus_write(1'b0, reg_key);
        wait_not_busy();
        next_cycle();
        while (!sample)
            next_cycle();
        bus_write(1'b1, data);
        m_key[ch] = on;
        if (on) begin
            m_phase[ch] = '0;
            m_fresh[ch] = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - err0);
        end
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        cur_test = "reset";
        check_status(cur_test, 8'h00, dout);
        check_irq(cur_test, 1'b1, irq_n);
        check_sample(cur_test, '0, left);
        check_sample(cur_test, '0, right);
        check_strobe(cur_test, 1'b0, sample);
        report_test(cur_test, err0);
    endtask

    task automatic busy_window();
        int err0;
        int cnt;
        err0 = errors;
        cur_test = "busy";
        set_channel(2'd0, '0, '0, 7'h15, 2'b11);   // steady phase, +level on both sides
        check_status(cur_test, 8'h80, dout);
        bus_write(1'b1, 8'h2a);                     // lands while busy
        cnt = 1;
        while (dout[7]) begin
            next_cycle();
            cnt++;
        end
        if (cnt <= (busy_ticks - 1) * clk_div || cnt > busy_ticks * clk_div) begin
            errors++;
            $display("busy: busy stayed high for %0d clocks, not %0d ticks", cnt, busy_ticks);
        end
        key_write(2'd0, 1'b1);
        wait_frames(2);
        check_sample(cur_test, sample_t'(7'h15), left);
        check_sample(cur_test, sample_t'(7'h15), right);
        key_write(2'd0, 1'b0);
        wait_frames(1);
        report_test(cur_test, err0);
    endtask

    task automatic timer_a_irq();
        int          err0;
        int          ticks;
        int          cnt;
        logic [31:0] rnd;
        logic [9:0]  value;
        err0 = errors;
        cur_test = "timer_a";
        rnd = $random(seed);
        ticks = 40 + int'(rnd[5:0]);
        value = 10'(1024 - ticks);
        write_reg(reg_tmr_a_hi, value[9:2]);
        write_reg(reg_tmr_a_lo, {6'd0, value[1:0]});
        write_reg(reg_tmr_ctl, 8'h05);    // load A with irq A
        cnt = 0;
        while (!dout[0]) begin
            next_cycle();
            cnt++;
        end
        if (cnt < (ticks - 1) * clk_div || cnt > (ticks + 1) * clk_div) begin
            errors++;
            $display("timer_a: flag set after %0d clocks, expected about %0d",
                     cnt, ticks * clk_div);
        end
        check_status(cur_test, 8'h01, dout);
        check_irq(cur_test, 1'b0, irq_n);
        write_reg(reg_tmr_ctl, 8'h14);    // clear A and stop, irq A kept on
        next_cycle();
        check_status(cur_test, 8'h80, dout);
        check_irq(cur_test, 1'b1, irq_n);
        report_test(cur_test, err0);
    endtask

    task automatic timer_b_masked();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        cur_test = "timer_b";
        rnd = $random(seed);
        write_reg(reg_tmr_b, 8'(256 - (2 + int'(rnd[1:0]))));
        write_reg(reg_tmr_ctl, 8'h02);    // load B, no irq
        while (!dout[1])
            next_cycle();
        check_irq(cur_test, 1'b1, irq_n);
        write_reg(reg_tmr_ctl, 8'h0a);    // irq B on
        check_irq(cur_test, 1'b0, irq_n);
        check_status(cur_test, 8'h82, dout);
        write_reg(reg_tmr_ctl, 8'h20);
        next_cycle();
        check_status(cur_test, 8'h80, dout);
        check_irq(cur_test, 1'b1, irq_n);
        report_test(cur_test, err0);
    endtask

    task automatic single_voice();
        int          err0;
        logic [31:0] rnd;
        logic [1:0]  pan;
        err0 = errors;
        cur_test = "voice";
        rnd = $random(seed);
        pan = (rnd[20:19] == 2'b00) ? 2'b11 : rnd[20:19];
        set_channel(2'd0, {1'b1, rnd[9:0]}, 3'd4 + {1'b0, rnd[11:10]}, rnd[18:12], pan);
        key_write(2'd0, 1'b1);
        wait_frames(40);
        key_write(2'd0, 1'b0);
        wait_frames(1);
        report_test(cur_test, err0);
    endtask

    task automatic three_voices();
        int          err0;
        logic [31:0] rnd;
        logic [1:0]  pans [num_ch] = '{2'b10, 2'b01, 2'b11};
        err0 = errors;
        cur_test = "mix";
        for (int ch = 0; ch < num_ch; ch++) begin
            rnd = $random(seed);
            set_channel(ch_t'(ch), {1'b1, rnd[9:0]}, 3'd4 + {1'b0, rnd[11:10]},
                        rnd[18:12], pans[ch]);
        end
        for (int ch = 0; ch < num_ch; ch++)
            key_write(ch_t'(ch), 1'b1);
        wait_frames(12);
        key_write(2'd1, 1'b0);            // gone from the next frame
        wait_frames(8);
        key_write(2'd0, 1'b0);
        key_write(2'd2, 1'b0);
        wait_frames(1);
        report_test(cur_test, err0);
    endtask

    initial begin
        arst_n = 1'b0;
        din    = '0;
        a0     = 1'b0;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        for (int ch = 0; ch < num_ch; ch++) begin
            m_fnum[ch]  = '0;
            m_block[ch] = '0;
            m_level[ch] = '0;
            m_pan[ch]   = '0;
            m_phase[ch] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        reset_state();
        busy_window();
        timer_a_irq();
        timer_b_masked();
        single_voice();
        three_voices();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* synth_core.f */
rtl/synth_regs_pkg.sv
rtl/synth_voice_pkg.sv
rtl/synth_timer.sv
rtl/synth_pg.sv
rtl/synth_acc.sv
rtl/synth_mmr.sv
rtl/synth_top.sv
test/synth_tb.sv

/* Makefile */
# Verilator build and run of the sound core testbench
VERILATOR ?= verilator
TOP       ?= synth_tb
FILELIST  ?= synth_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
